// File: Bender.yml
package:
  name: mmio_periph

sources:
  - logic/mmio_pkg.sv
  - logic/mmio_decoder.sv
  - logic/data_ram.sv
  - logic/fact_accel.sv
  - logic/gpio_port.sv
  - logic/mmio_top.sv
  - target: simulation
    files:
      - verif/mmio_checker.sv
      - verif/mmio_tb.sv

// File: all.f
logic/mmio_pkg.sv
logic/mmio_decoder.sv
logic/data_ram.sv
logic/fact_accel.sv
logic/gpio_port.sv
logic/mmio_top.sv
verif/mmio_checker.sv
verif/mmio_tb.sv

// File: logic/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  we,
    input  wire  [mmio_pkg::RAM_IDX_W-1:0]       word_idx,
    input  wire  [mmio_pkg::DATA_W-1:0]          wdata,
    output logic [mmio_pkg::DATA_W-1:0]          rdata
);

    // Word storage
    logic [mmio_pkg::DATA_W-1:0] mem [mmio_pkg::RAM_WORDS];

    // Synchronous write port
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[word_idx] <= wdata;
        end
    end

    ////////////////////
    // Read register
    ////////////////////
    // Loaded every cycle from the addressed word
    // the decoder picks it up only after a read
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rdata <= '0;
        end
        else
        begin
            rdata <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

// File: logic/fact_accel.sv
`timescale 1ns/10ps
`default_nettype none

module fact_accel (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  we,
    input  wire  [mmio_pkg::REG_IDX_W-1:0]       reg_idx,
    input  wire  [mmio_pkg::DATA_W-1:0]          wdata,
    output logic [mmio_pkg::DATA_W-1:0]          rdata
);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } fact_state_e;

    fact_state_e                      state_q;
    logic [mmio_pkg::FACT_N_W-1:0]    n_q;
    // Upper bits of the written operand were nonzero
    logic                             n_ovf_q;
    logic [mmio_pkg::FACT_N_W-1:0]    idx_q;
    logic [mmio_pkg::DATA_W-1:0]      acc_q;
    logic                             done_q;
    logic                             err_q;
    logic                             busy;
    logic                             go_start;
    logic                             n_bad;

    assign busy     = (state_q == ST_RUN);
    // GO is only taken while idle
    assign go_start = we && (reg_idx == mmio_pkg::FACT_REG_GO) && wdata[0] && !busy;
    assign n_bad    = n_ovf_q || (n_q > mmio_pkg::FACT_MAX_N);

    ////////////////////
    // Engine
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state_q <= ST_IDLE;
            n_q     <= '0;
            n_ovf_q <= 1'b0;
            idx_q   <= '0;
            acc_q   <= '0;
            done_q  <= 1'b0;
            err_q   <= 1'b0;
        end
        else
        begin
            // Operand may be rewritten at any time, used only at GO
            if (we && (reg_idx == mmio_pkg::FACT_REG_N))
            begin
                n_q     <= wdata[mmio_pkg::FACT_N_W-1:0];
                n_ovf_q <= |wdata[mmio_pkg::DATA_W-1:mmio_pkg::FACT_N_W];
            end
            case (state_q)
                ST_IDLE:
                begin
                    if (go_start)
                    begin
                        err_q <= n_bad;
                        if (n_bad)
                        begin
                            // Out of range, flag and finish at once
                            acc_q  <= '0;
                            done_q <= 1'b1;
                        end
                        else if (n_q <= 4'd1)
                        begin
                            acc_q  <= 32'd1;
                            done_q <= 1'b1;
                        end
                        else
                        begin
                            acc_q   <= mmio_pkg::DATA_W'(n_q);
                            idx_q   <= n_q - 4'd1;
                            done_q  <= 1'b0;
                            state_q <= ST_RUN;
                        end
                    end
                end
                default:
                begin
                    // One multiply per cycle down to index one
                    acc_q <= acc_q * mmio_pkg::DATA_W'(idx_q);
                    idx_q <= idx_q - 4'd1;
                    if (idx_q == 4'd1)
                    begin
                        done_q  <= 1'b1;
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    ////////////////////
    // Read register
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rdata <= '0;
        end
        else
        begin
            case (reg_idx)
                mmio_pkg::FACT_REG_N:      rdata <= mmio_pkg::DATA_W'(n_q);
                mmio_pkg::FACT_REG_STATUS: rdata <= {29'd0, busy, err_q, done_q};
                mmio_pkg::FACT_REG_RESULT: rdata <= acc_q;
                // GO reads as zero
                default:                   rdata <= '0;
            endcase
        end
    end

    // Result holds while idle unless a new run is launched
    a_acc_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (!busy && !go_start) |=> $stable(acc_q));

    // Status never shows busy and done together
    a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done_q));

endmodule

`default_nettype wire

// File: logic/gpio_port.sv
`timescale 1ns/10ps
`default_nettype none

module gpio_port (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  we,
    input  wire  [mmio_pkg::REG_IDX_W-1:0]       reg_idx,
    input  wire  [mmio_pkg::DATA_W-1:0]          wdata,
    input  wire  [mmio_pkg::GPI_W-1:0]           gpi,
    output logic [mmio_pkg::DATA_W-1:0]          gpo1,
    output logic [mmio_pkg::DATA_W-1:0]          gpo2,
    output logic [mmio_pkg::DATA_W-1:0]          rdata
);

    // Input pins sampled every cycle
    logic [mmio_pkg::GPI_W-1:0] gpi_q;

    ////////////////////
    // Pin registers
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            gpi_q <= '0;
            gpo1  <= '0;
            gpo2  <= '0;
        end
        else
        begin
            gpi_q <= gpi;
            // Writes to IN and offset 3 fall through
            if (we && (reg_idx == mmio_pkg::GPIO_REG_OUT1))
            begin
                gpo1 <= wdata;
            end
            if (we && (reg_idx == mmio_pkg::GPIO_REG_OUT2))
            begin
                gpo2 <= wdata;
            end
        end
    end

    // Registered read port
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rdata <= '0;
        end
        else
        begin
            case (reg_idx)
                mmio_pkg::GPIO_REG_IN:   rdata <= mmio_pkg::DATA_W'(gpi_q);
                mmio_pkg::GPIO_REG_OUT1: rdata <= gpo1;
                mmio_pkg::GPIO_REG_OUT2: rdata <= gpo2;
                default:                 rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/mmio_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_decoder (
    input  wire                                clk,
    input  wire                                rst_n,
    input  wire  mmio_pkg::mmio_req_t          req,
    output logic                               ram_we,
    output logic                               fact_we,
    output logic                               gpio_we,
    input  wire  [mmio_pkg::DATA_W-1:0]        ram_rdata,
    input  wire  [mmio_pkg::DATA_W-1:0]        fact_rdata,
    input  wire  [mmio_pkg::DATA_W-1:0]        gpio_rdata,
    output mmio_pkg::mmio_rsp_t                rsp
);

    // Block hit by the current address
    mmio_pkg::periph_sel_e addr_sel;
    // Block recorded at the read strobe
    mmio_pkg::periph_sel_e rd_sel_q;
    // A read is answered this cycle
    logic                  rd_pend_q;

    ////////////////////
    // Address decode
    ////////////////////
    always_comb
    begin
        if (req.addr[mmio_pkg::ADDR_W-1:mmio_pkg::RAM_SPAN_W] ==
            mmio_pkg::RAM_BASE[mmio_pkg::ADDR_W-1:mmio_pkg::RAM_SPAN_W])
        begin
            addr_sel = mmio_pkg::SEL_RAM;
        end
        else if (req.addr[mmio_pkg::ADDR_W-1:mmio_pkg::BLK_SPAN_W] ==
                 mmio_pkg::FACT_BASE[mmio_pkg::ADDR_W-1:mmio_pkg::BLK_SPAN_W])
        begin
            addr_sel = mmio_pkg::SEL_FACT;
        end
        else if (req.addr[mmio_pkg::ADDR_W-1:mmio_pkg::BLK_SPAN_W] ==
                 mmio_pkg::GPIO_BASE[mmio_pkg::ADDR_W-1:mmio_pkg::BLK_SPAN_W])
        begin
            addr_sel = mmio_pkg::SEL_GPIO;
        end
        else
        begin
            addr_sel = mmio_pkg::SEL_NONE;
        end
    end

    // At most one write strobe
    // Unmapped writes are dropped here
    assign ram_we  = req.wr && (addr_sel == mmio_pkg::SEL_RAM);
    assign fact_we = req.wr && (addr_sel == mmio_pkg::SEL_FACT);
    assign gpio_we = req.wr && (addr_sel == mmio_pkg::SEL_GPIO);

    ////////////////////
    // Read tracking
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rd_pend_q <= 1'b0;
            rd_sel_q  <= mmio_pkg::SEL_NONE;
        end
        else
        begin
            rd_pend_q <= req.rd;
            // Select only moves on a read so it stays put otherwise
            if (req.rd)
            begin
                rd_sel_q <= addr_sel;
            end
        end
    end

    // Response mux over the registered block outputs
    always_comb
    begin
        rsp.valid = rd_pend_q;
        rsp.err   = rd_pend_q && (rd_sel_q == mmio_pkg::SEL_NONE);
        case (rd_sel_q)
            mmio_pkg::SEL_RAM:  rsp.rdata = ram_rdata;
            mmio_pkg::SEL_FACT: rsp.rdata = fact_rdata;
            mmio_pkg::SEL_GPIO: rsp.rdata = gpio_rdata;
            default:            rsp.rdata = '0;
        endcase
    end

    // Master never raises both strobes
    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(req.rd && req.wr));

endmodule

`default_nettype wire

// File: logic/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    ////////////////////
    // Bus widths
    ////////////////////
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // RAM geometry and index widths
    localparam int RAM_WORDS  = 64;
    localparam int RAM_IDX_W  = $clog2(RAM_WORDS);
    localparam int REG_IDX_W  = 2;
    localparam int RAM_SPAN_W = RAM_IDX_W + 2;
    localparam int BLK_SPAN_W = REG_IDX_W + 2;
    localparam int GPI_W      = 8;

    ////////////////////
    // Address map
    ////////////////////
    localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] FACT_BASE = 32'h0000_0800;
    localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h0000_0900;

    // Factorial block register offsets
    localparam logic [REG_IDX_W-1:0] FACT_REG_N      = 2'd0;
    localparam logic [REG_IDX_W-1:0] FACT_REG_GO     = 2'd1;
    localparam logic [REG_IDX_W-1:0] FACT_REG_STATUS = 2'd2;
    localparam logic [REG_IDX_W-1:0] FACT_REG_RESULT = 2'd3;

    // GPIO register offsets, offset 3 reads zero
    localparam logic [REG_IDX_W-1:0] GPIO_REG_IN   = 2'd0;
    localparam logic [REG_IDX_W-1:0] GPIO_REG_OUT1 = 2'd1;
    localparam logic [REG_IDX_W-1:0] GPIO_REG_OUT2 = 2'd2;

    // Largest operand whose factorial fits one word
    localparam int                  FACT_N_W   = 4;
    localparam logic [FACT_N_W-1:0] FACT_MAX_N = 4'd12;

    ////////////////////
    // Bus types
    ////////////////////
    typedef struct packed {
        logic              wr;
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mmio_req_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } mmio_rsp_t;

    typedef enum logic [1:0] {
        SEL_RAM,
        SEL_FACT,
        SEL_GPIO,
        SEL_NONE
    } periph_sel_e;

endpackage

`default_nettype wire

// File: logic/mmio_top.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_top (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  mmio_pkg::mmio_req_t            req,
    output mmio_pkg::mmio_rsp_t                  rsp,
    input  wire  [mmio_pkg::GPI_W-1:0]           gpi,
    output logic [mmio_pkg::DATA_W-1:0]          gpo1,
    output logic [mmio_pkg::DATA_W-1:0]          gpo2
);

    // Block write strobes
    logic                              ram_we;
    logic                              fact_we;
    logic                              gpio_we;
    // Registered block read data
    logic [mmio_pkg::DATA_W-1:0]       ram_rdata;
    logic [mmio_pkg::DATA_W-1:0]       fact_rdata;
    logic [mmio_pkg::DATA_W-1:0]       gpio_rdata;
    // Word and register index sliced from the byte address
    logic [mmio_pkg::RAM_IDX_W-1:0]    word_idx;
    logic [mmio_pkg::REG_IDX_W-1:0]    reg_idx;

    assign word_idx = req.addr[mmio_pkg::RAM_SPAN_W-1:2];
    assign reg_idx  = req.addr[mmio_pkg::BLK_SPAN_W-1:2];

    ////////////////////
    // Decoder
    ////////////////////
    mmio_decoder mmio_decoder_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .ram_we     (ram_we),
        .fact_we    (fact_we),
        .gpio_we    (gpio_we),
        .ram_rdata  (ram_rdata),
        .fact_rdata (fact_rdata),
        .gpio_rdata (gpio_rdata),
        .rsp        (rsp)
    );

    ////////////////////
    // Peripherals
    ////////////////////
    data_ram data_ram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .we       (ram_we),
        .word_idx (word_idx),
        .wdata    (req.wdata),
        .rdata    (ram_rdata)
    );

    fact_accel fact_accel_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (fact_we),
        .reg_idx (reg_idx),
        .wdata   (req.wdata),
        .rdata   (fact_rdata)
    );

    gpio_port gpio_port_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (gpio_we),
        .reg_idx (reg_idx),
        .wdata   (req.wdata),
        .gpi     (gpi),
        .gpo1    (gpo1),
        .gpo2    (gpo2),
        .rdata   (gpio_rdata)
    );

endmodule

`default_nettype wire

// File: verif/mmio_checker.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_checker (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  mmio_pkg::mmio_req_t            req,
    input  wire  mmio_pkg::mmio_rsp_t            rsp,
    input  wire  [mmio_pkg::GPI_W-1:0]           gpi,
    input  wire  [mmio_pkg::DATA_W-1:0]          gpo1,
    input  wire  [mmio_pkg::DATA_W-1:0]          gpo2,
    input  wire  mmio_pkg::mmio_rsp_t            file_exp,
    output int                                   errors_total
);

    // Read in flight with its expected answer
    typedef struct packed {
        logic [mmio_pkg::ADDR_W-1:0] addr;
        mmio_pkg::mmio_rsp_t         exp;
    } pend_t;

    pend_t                         pend_q[$];
    // Reference model state
    logic [mmio_pkg::DATA_W-1:0]   ram_model [mmio_pkg::RAM_WORDS];
    logic [mmio_pkg::DATA_W-1:0]   gpo1_model;
    logic [mmio_pkg::DATA_W-1:0]   gpo2_model;
    logic [mmio_pkg::GPI_W-1:0]    gpi_model;
    logic [3:0]                    n_model;
    logic                          n_ovf_model;
    logic                          done_model;
    logic                          err_model;
    logic [mmio_pkg::DATA_W-1:0]   result_model;
    int                            busy_cnt;
    logic                          fact_was_busy;
    // Per test and overall counts
    logic [8*32-1:0]               cur_name;
    logic                          test_active = 1'b0;
    int                            test_checks = 0;
    int                            test_errors = 0;
    int                            tests_passed = 0;
    int                            tests_failed = 0;
    int                            checks_total = 0;

    initial errors_total = 0;

    function automatic logic [31:0] fact_of(input int n);
        logic [31:0] prod;
        prod = 32'd1;
        for (int k = 2; k <= n; k++)
        begin
            prod = prod * k;
        end
        return prod;
    endfunction

    // Block hit by an address, from the address map
    function automatic mmio_pkg::periph_sel_e block_of(input logic [31:0] addr);
        if (addr[31:8] == mmio_pkg::RAM_BASE[31:8])
            return mmio_pkg::SEL_RAM;
        if (addr[31:4] == mmio_pkg::FACT_BASE[31:4])
            return mmio_pkg::SEL_FACT;
        if (addr[31:4] == mmio_pkg::GPIO_BASE[31:4])
            return mmio_pkg::SEL_GPIO;
        return mmio_pkg::SEL_NONE;
    endfunction

    ////////////////////
    // Model access
    ////////////////////
    function automatic mmio_pkg::mmio_rsp_t model_read(input logic [31:0] addr);
        mmio_pkg::mmio_rsp_t r;
        r = {1'b1, 1'b0, 32'd0};
        case (block_of(addr))
            mmio_pkg::SEL_RAM:  r.rdata = ram_model[addr[7:2]];
            mmio_pkg::SEL_FACT:
            begin
                case (addr[3:2])
                    2'd0:    r.rdata = {28'd0, n_model};
                    2'd2:    r.rdata = {29'd0, busy_cnt != 0, err_model, done_model};
                    2'd3:    r.rdata = result_model;
                    default: r.rdata = '0;
                endcase
            end
            mmio_pkg::SEL_GPIO:
            begin
                case (addr[3:2])
                    2'd0:    r.rdata = {24'd0, gpi_model};
                    2'd1:    r.rdata = gpo1_model;
                    2'd2:    r.rdata = gpo2_model;
                    default: r.rdata = '0;
                endcase
            end
            default:            r.err = 1'b1;
        endcase
        return r;
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] wdata);
        logic bad;
        case (block_of(addr))
            mmio_pkg::SEL_RAM:  ram_model[addr[7:2]] = wdata;
            mmio_pkg::SEL_FACT:
            begin
                if (addr[3:2] == 2'd0)
                begin
                    n_model     = wdata[3:0];
                    n_ovf_model = |wdata[31:4];
                end
                // GO is dropped while a run is busy
                if (addr[3:2] == 2'd1 && wdata[0] && !fact_was_busy)
                begin
                    bad       = n_ovf_model || (n_model > mmio_pkg::FACT_MAX_N);
                    err_model = bad;
                    if (bad)
                    begin
                        result_model = '0;
                        done_model   = 1'b1;
                    end
                    else
                    begin
                        result_model = fact_of(n_model);
                        busy_cnt     = (n_model > 1) ? n_model - 1 : 0;
                        done_model   = (busy_cnt == 0);
                    end
                end
            end
            mmio_pkg::SEL_GPIO:
            begin
                if (addr[3:2] == 2'd1)
                    gpo1_model = wdata;
                if (addr[3:2] == 2'd2)
                    gpo2_model = wdata;
            end
            default: ;
        endcase
    endtask

    task automatic note_error;
        test_errors++;
        errors_total++;
    endtask

    ////////////////////
    // Per cycle checks
    ////////////////////
    task automatic check_response;
        pend_t p;
        if (rsp.valid && pend_q.size() == 0)
        begin
            $display("Response arrived at %0t ns with no read outstanding", $time);
            note_error();
        end
        else if (pend_q.size() != 0)
        begin
            p = pend_q.pop_front();
            if (!rsp.valid)
            begin
                $display("No response arrived at %0t ns for the read of %08h", $time, p.addr);
                note_error();
            end
            else
            begin
                test_checks++;
                checks_total++;
                if (rsp.err !== p.exp.err || rsp.rdata !== p.exp.rdata)
                begin
                    $display("ERR %0t ns: read of %08h gave %08h err %0b, expected %08h err %0b",
                             $time, p.addr, rsp.rdata, rsp.err, p.exp.rdata, p.exp.err);
                    note_error();
                end
            end
        end
    endtask

    task automatic check_pins;
        if (gpo1 !== gpo1_model || gpo2 !== gpo2_model)
        begin
            $display("ERR %0t ns: gpo1 %08h gpo2 %08h, expected %08h and %08h",
                     $time, gpo1, gpo2, gpo1_model, gpo2_model);
            note_error();
        end
    endtask

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            pend_q.delete();
            gpo1_model   = '0;
            gpo2_model   = '0;
            gpi_model    = '0;
            n_model      = '0;
            n_ovf_model  = 1'b0;
            done_model   = 1'b0;
            err_model    = 1'b0;
            result_model = '0;
            busy_cnt     = 0;
        end
        else
        begin
            // Compare first, the model still holds the state before this edge
            check_response();
            check_pins();
            fact_was_busy = (busy_cnt != 0);
            if (req.rd)
            begin
                pend_q.push_back({req.addr, file_exp.valid ? file_exp : model_read(req.addr)});
            end
            if (req.wr)
            begin
                model_write(req.addr, req.wdata);
            end
            // One multiply per cycle in the DUT
            if (fact_was_busy)
            begin
                busy_cnt--;
                if (busy_cnt == 0)
                    done_model = 1'b1;
            end
            gpi_model = gpi;
        end
    end

    ////////////////////
    // Reporting
    ////////////////////
    task automatic start_test(input logic [8*32-1:0] name);
        cur_name    = name;
        test_checks = 0;
        test_errors = 0;
        test_active = 1'b1;
    endtask

    task automatic end_test;
        if (test_active)
        begin
            if (test_errors == 0)
            begin
                $display("%0s: PASS, %0d reads checked", cur_name, test_checks);
                tests_passed++;
            end
            else
            begin
                $display("%0s: FAIL, %0d errors", cur_name, test_errors);
                tests_failed++;
            end
            test_active = 1'b0;
        end
    endtask

    task automatic print_counts;
        $display("Tests %0d passed %0d failed, reads checked %0d, errors %0d",
                 tests_passed, tests_failed, checks_total, errors_total);
    endtask

endmodule

`default_nettype wire

// File: verif/mmio_input.txt
# op arg1 arg2: test name, wr addr data, rd addr expected, rderr addr
# fact first_n last_n, busygo n n_late, gpi value; addresses and data in hex
test ram_basic
wr 00000000 12345678
wr 000000fc cafef00d
rd 00000000 12345678
rd 000000fc cafef00d
test back_to_back
wr 00000010 0000aaaa
wr 00000904 00005555
rd 00000010 0000aaaa
rd 00000904 00005555
rd 00000000 12345678
rd 00000800 00000000
test fact_range
fact 0 12
test fact_bad
fact 13 16
busygo 9 3
test gpio
wr 00000904 a5a5a5a5
wr 00000908 0000beef
rd 00000904 a5a5a5a5
rd 00000908 0000beef
gpi 3c
rd 00000900 0000003c
rd 0000090c 00000000
test unmapped
rderr 00000400
rderr 00000810
wr 00000100 ffffffff
wr 00000a04 ffffffff
rd 00000000 12345678
rd 00000904 a5a5a5a5

// File: verif/mmio_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mmio_tb;

    logic                         clk;
    logic                         rst_n;
    mmio_pkg::mmio_req_t          req;
    mmio_pkg::mmio_rsp_t          rsp;
    logic [mmio_pkg::GPI_W-1:0]   gpi;
    logic [mmio_pkg::DATA_W-1:0]  gpo1;
    logic [mmio_pkg::DATA_W-1:0]  gpo2;
    // Expected response from the data file, valid bit marks a file value
    mmio_pkg::mmio_rsp_t          file_exp;
    int                           err_count;
    int                           bad_lines;
    longint                       limit_ns;
    int                           fd;
    int                           rand_words = 32;
    logic [8*128-1:0]             line_buf;
    logic [8*128-1:0]             lines_q[$];

    ////////////////////
    // Clock and DUT
    ////////////////////
    initial clk = 1'b0;
    always #2 clk = ~clk;

    mmio_top mmio_top_i (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .rsp   (rsp),
        .gpi   (gpi),
        .gpo1  (gpo1),
        .gpo2  (gpo2)
    );

    mmio_checker mmio_checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .rsp          (rsp),
        .gpi          (gpi),
        .gpo1         (gpo1),
        .gpo2         (gpo2),
        .file_exp     (file_exp),
        .errors_total (err_count)
    );

    // Byte address of a block register
    function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [1:0] idx);
        return base | {28'd0, idx, 2'b00};
    endfunction

    ////////////////////
    // Bus driver
    ////////////////////
    // One request per falling edge
    task automatic put_req(input logic wr_bit, input logic rd_bit, input logic [31:0] addr,
                           input logic [31:0] wdata, input mmio_pkg::mmio_rsp_t exp);
        @(negedge clk);
        req.wr    = wr_bit;
        req.rd    = rd_bit;
        req.addr  = addr;
        req.wdata = wdata;
        file_exp  = exp;
    endtask

    task automatic bus_idle;
        put_req(1'b0, 1'b0, '0, '0, '0);
    endtask

    // Drain the pipe so the checker has seen the last response
    task automatic close_test;
        bus_idle();
        bus_idle();
        mmio_checker_i.end_test();
    endtask

    // Poll STATUS until done with busy clear
    task automatic poll_done;
        logic done_seen;
        done_seen = 1'b0;
        while (!done_seen)
        begin
            put_req(1'b0, 1'b1, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_STATUS),
                    '0, '0);
            bus_idle();
            done_seen = rsp.valid && rsp.rdata[0] && !rsp.rdata[2];
        end
    endtask

    task automatic run_factorial(input int n);
        put_req(1'b1, 1'b0, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_N), n, '0);
        put_req(1'b1, 1'b0, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_GO), 32'd1, '0);
        poll_done();
        put_req(1'b0, 1'b1, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_RESULT), '0, '0);
        bus_idle();
    endtask

    // Second GO lands while the first run is busy
    task automatic run_busy_go(input int n, input int n_late);
        put_req(1'b1, 1'b0, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_N), n, '0);
        put_req(1'b1, 1'b0, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_GO), 32'd1, '0);
        put_req(1'b1, 1'b0, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_N), n_late, '0);
        put_req(1'b1, 1'b0, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_GO), 32'd1, '0);
        poll_done();
        put_req(1'b0, 1'b1, reg_addr(mmio_pkg::FACT_BASE, mmio_pkg::FACT_REG_RESULT), '0, '0);
        bus_idle();
    endtask

    task automatic apply_gpi(input logic [7:0] value);
        @(negedge clk);
        req      = '0;
        file_exp = '0;
        gpi      = value;
    endtask

    // Random writes then readback of every address written
    task automatic random_ram_phase;
        logic [31:0] addrs[$];
        for (int i = 0; i < rand_words; i++)
        begin
            addrs.push_back(($urandom % mmio_pkg::RAM_WORDS) << 2);
            put_req(1'b1, 1'b0, addrs[i], $urandom, '0);
        end
        for (int i = 0; i < rand_words; i++)
        begin
            put_req(1'b0, 1'b1, addrs[i], '0, '0);
        end
    endtask

    ////////////////////
    // Data file lines
    ////////////////////
    task automatic run_line(input logic [8*128-1:0] line);
        logic [8*16-1:0] op;
        logic [8*32-1:0] name;
        logic [31:0]     a;
        logic [31:0]     b;
        int              lo;
        int              hi;
        int              cnt;
        op  = '0;
        cnt = $sscanf(line, "%s", op);
        if (cnt < 1 || op == "#")
        begin
            return;
        end
        case (op)
            "test":
            begin
                name = '0;
                cnt  = $sscanf(line, "%s %s", op, name);
                close_test();
                mmio_checker_i.start_test(name);
            end
            "wr":
            begin
                cnt = $sscanf(line, "%s %h %h", op, a, b);
                put_req(1'b1, 1'b0, a, b, '0);
            end
            "rd":
            begin
                cnt = $sscanf(line, "%s %h %h", op, a, b);
                put_req(1'b0, 1'b1, a, '0, {1'b1, 1'b0, b});
            end
            "rderr":
            begin
                cnt = $sscanf(line, "%s %h", op, a);
                put_req(1'b0, 1'b1, a, '0, {1'b1, 1'b1, 32'd0});
            end
            "fact":
            begin
                cnt = $sscanf(line, "%s %d %d", op, lo, hi);
                for (int k = lo; k <= hi; k++)
                begin
                    run_factorial(k);
                end
            end
            "busygo":
            begin
                cnt = $sscanf(line, "%s %d %d", op, lo, hi);
                run_busy_go(lo, hi);
            end
            "gpi":
            begin
                cnt = $sscanf(line, "%s %h", op, a);
                apply_gpi(a[7:0]);
            end
            default:
            begin
                $display("Unknown operation in the input file: %0s", op);
                bad_lines++;
            end
        endcase
    endtask

    ////////////////////
    // Main flow
    ////////////////////
    initial
    begin
        req       = '0;
        file_exp  = '0;
        gpi       = '0;
        rst_n     = 1'b0;
        bad_lines = 0;
        limit_ns  = 0;
        void'($urandom(14620));
        fd = $fopen("verif/mmio_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verif/mmio_input.txt for reading");
            $display("Something failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line_buf = '0;
                if ($fgets(line_buf, fd) > 0)
                begin
                    lines_q.push_back(line_buf);
                end
            end
            $fclose(fd);
            limit_ns = 4 * (lines_q.size() * 40 + rand_words * 2 * 4 + 1000);
            repeat (10) @(negedge clk);
            rst_n = 1'b1;
            foreach (lines_q[i])
            begin
                run_line(lines_q[i]);
            end
            close_test();
            mmio_checker_i.start_test("random_ram");
            random_ram_phase();
            close_test();
            mmio_checker_i.print_counts();
            if (err_count == 0 && bad_lines == 0)
            begin
                $display("Everything OK");
            end
            else
            begin
                $display("Something failed");
            end
            $finish;
        end
    end

    // Watchdog armed once the line count is known
    initial
    begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
